//--- source/idu_pkg.sv
// shared types for the issue control; unit select bit order is fixed as alu down to cp0
package idu_pkg;

  // default operand counts of one decoded instruction
  localparam int NUM_SRC = 3;
  localparam int NUM_DST = 2;

  // ------------------------------------------------------------
  // producing unit as kept by the write-back tracker
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    WB_ALU  = 3'd0,
    WB_BJU  = 3'd1,
    WB_LSU  = 3'd2,
    WB_MULT = 3'd3,
    WB_DIV  = 3'd4,
    WB_CP0  = 3'd5
  } wb_type_e;

  // tracker summary for one register
  typedef struct packed {
    // set when nothing is pending on the register
    logic       vld;
    wb_type_e   wb_type;
    // pending producers minus one, saturates at 2
    logic [1:0] cnt;
    // first of two producers writes back this cycle
    logic       wb_cnt2;
  } wb_info_t;

  // ------------------------------------------------------------
  // execution unit selects and fullness
  // ------------------------------------------------------------
  typedef struct packed {
    logic alu;
    logic bju;
    logic mult;
    logic div;
    logic lsu;
    logic cp0;
  } eu_sel_t;

  // alu and cp0 never report full
  typedef struct packed {
    logic bju;
    logic mult;
    logic div;
    logic lsu;
  } eu_full_t;

  // performance counter event bits
  typedef struct packed {
    logic int_inst;
    logic lsu_inst;
    logic csr_inst;
    logic sync_inst;
    logic ecall_inst;
  } hpcp_type_t;

endpackage

//--- source/idu_ex1_if.sv
// pure wiring between dispatch and ex1, holds no state and no clock
`timescale 1ns/1ns
interface idu_ex1_if;
  import idu_pkg::*;

  // dispatch side
  logic    pipedown_vld;
  eu_sel_t pipedown_eu_sel;
  // ex1 side
  logic    ex1_inst_vld;
  eu_sel_t ex1_eu_sel;
  logic    ex1_stall;

  modport dis   (output pipedown_vld, output pipedown_eu_sel, input ex1_stall);
  modport stage (input pipedown_vld, input pipedown_eu_sel, input ex1_stall,
                 output ex1_inst_vld, output ex1_eu_sel);
  modport issue (input ex1_inst_vld, input ex1_eu_sel, output ex1_stall);

endinterface

//--- source/idu_raw_chk.sv
// raw check is pure logic; the last source is taken as the store data operand
`timescale 1ns/1ns
module idu_raw_chk #(
  parameter int NUM_SRC = idu_pkg::NUM_SRC
) (
  input  logic [NUM_SRC-1:0] src_vld,
  input  logic [NUM_SRC-1:0] src_fwd_vld,
  input  idu_pkg::wb_info_t  src_info [NUM_SRC],
  input  logic               src_is_bju,
  input  logic               condbr,
  input  logic               store,
  output logic               raw
);
  import idu_pkg::*;

  logic [NUM_SRC-1:0] src_raw;

  for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
    localparam bit IS_DATA = (i == NUM_SRC - 1);
    wb_type_e prod;
    logic     cnt_low;
    logic     fwd_ok;
    logic     except;

    assign prod    = src_info[i].wb_type;
    // one or two pending producers
    assign cnt_low = (src_info[i].cnt == 2'd0) || (src_info[i].cnt == 2'd1);

    // forwarding cannot cover a deep lsu/mult queue
    assign fwd_ok  = src_fwd_vld[i]
                     && !(((prod == WB_LSU) || (prod == WB_MULT))
                          && (src_info[i].cnt == 2'd2));

    // alu/bju results forward from ex1
    assign except  = (prod == WB_ALU) || (prod == WB_BJU)
                     // load into conditional branch
                     || ((prod == WB_LSU) && src_is_bju && condbr && cnt_low)
                     || fwd_ok
                     // load into store data, late enough for the lsu
                     || (IS_DATA && (prod == WB_LSU) && store
                         && (cnt_low || src_info[i].wb_cnt2));

    assign src_raw[i] = src_vld[i] && !src_info[i].vld && !except;
  end

  assign raw = |src_raw;

endmodule

//--- source/idu_waw_chk.sv
// waw check is pure logic over every destination of the instruction
`timescale 1ns/1ns
module idu_waw_chk #(
  parameter int NUM_DST = idu_pkg::NUM_DST
) (
  input  logic [NUM_DST-1:0] dst_vld,
  input  idu_pkg::wb_type_e  dst_type [NUM_DST],
  input  idu_pkg::wb_info_t  dst_info [NUM_DST],
  output logic               waw
);
  import idu_pkg::*;

  logic [NUM_DST-1:0] dst_waw;

  for (genvar i = 0; i < NUM_DST; i++) begin : g_dst
    wb_type_e old_prod;
    logic     same_pipe;
    logic     shallow;
    logic     except;

    assign old_prod  = dst_info[i].wb_type;
    // lsu and mult write back in order within their own unit
    assign same_pipe = ((old_prod == WB_LSU) && (dst_type[i] == WB_LSU))
                       || ((old_prod == WB_MULT) && (dst_type[i] == WB_MULT));
    assign shallow   = (dst_info[i].cnt == 2'd0) || (dst_info[i].cnt == 2'd1)
                       || dst_info[i].wb_cnt2;

    assign except    = (old_prod == WB_ALU) || (old_prod == WB_BJU)
                       || (same_pipe && shallow);

    assign dst_waw[i] = dst_vld[i] && !dst_info[i].vld && !except;
  end

  assign waw = |dst_waw;

endmodule

//--- source/idu_dis_ctrl.sv
// dispatch stall and pipedown select, combinational in the id cycle
`timescale 1ns/1ns
module idu_dis_ctrl (
  input  logic             id_inst_vld,
  input  logic             raw,
  input  logic             waw,
  input  logic             cp0_fence,
  input  logic             pipeline_empty,
  input  logic             dbgon,
  input  logic             dis_fence_in_dbg,
  input  logic             flush_stall,
  input  logic             expt_vld,
  input  logic             inst_cancel,
  input  idu_pkg::eu_sel_t dis_eu,
  output logic             dis_stall,
  idu_ex1_if.dis           ex1
);
  import idu_pkg::*;

  logic    dep_stall;
  logic    fence_stall;
  eu_sel_t dis_eu_fix;

  // ------------------------------------------------------------
  // stall sources
  // ------------------------------------------------------------
  assign dep_stall   = id_inst_vld && (raw || waw);

  // fence waits for older insts to retire
  // debug mode may bypass so a hung pipe can still be probed
  assign fence_stall = id_inst_vld && cp0_fence && !pipeline_empty
                       && !(dbgon && dis_fence_in_dbg);

  assign dis_stall   = flush_stall || ex1.ex1_stall || dep_stall || fence_stall;

  // ------------------------------------------------------------
  // pipedown
  // ------------------------------------------------------------
  // faulting or cancelled insts go to cp0 alone
  always_comb begin
    if (expt_vld || inst_cancel) begin
      dis_eu_fix     = '0;
      dis_eu_fix.cp0 = 1'b1;
    end else begin
      dis_eu_fix = dis_eu;
    end
  end

  assign ex1.pipedown_vld    = id_inst_vld && !dis_stall;
  assign ex1.pipedown_eu_sel = ex1.pipedown_vld ? dis_eu_fix : '0;

endmodule

//--- source/idu_ex1_stage.sv
// ex1 valid and one-hot unit select, cleared by reset or flush
`timescale 1ns/1ns
module idu_ex1_stage (
  input  logic     ex1_hpcp_clk,
  input  logic     cpurst_b,
  input  logic     flush,
  idu_ex1_if.stage ex1
);

  // flush wins over stall
  // held inst stays put until its unit frees up
  always_ff @(posedge ex1_hpcp_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex1.ex1_inst_vld <= 1'b0;
      ex1.ex1_eu_sel   <= '0;
    end else if (flush) begin
      ex1.ex1_inst_vld <= 1'b0;
      ex1.ex1_eu_sel   <= '0;
    end else if (!ex1.ex1_stall) begin
      ex1.ex1_inst_vld <= ex1.pipedown_vld;
      ex1.ex1_eu_sel   <= ex1.pipedown_eu_sel;
    end
  end

endmodule

//--- source/idu_eu_issue.sv
// issue selects from ex1; alu and cp0 have no full signal of their own
`timescale 1ns/1ns
module idu_eu_issue (
  input  logic              commit,
  input  idu_pkg::eu_full_t eu_full,
  input  logic              bju_global_full,
  input  logic              lsu_global_full,
  input  logic              mult_issue_stall,
  input  logic              cp0_issue_stall,
  output idu_pkg::eu_sel_t  issue_sel,
  output idu_pkg::eu_sel_t  dp_sel,
  output logic              ex1_pipedown_vld,
  idu_ex1_if.issue          ex1
);

  logic int_stall;
  logic eu_full_hit;
  logic issue_stall;

  // ------------------------------------------------------------
  // ex1 stall reasons
  // ------------------------------------------------------------
  // global full blocks every unit
  assign int_stall   = ex1.ex1_inst_vld && (bju_global_full || lsu_global_full);

  // own unit full, inst holds without a select
  assign eu_full_hit = (ex1.ex1_eu_sel.bju && eu_full.bju)
                       || (ex1.ex1_eu_sel.mult && eu_full.mult)
                       || (ex1.ex1_eu_sel.div && eu_full.div)
                       || (ex1.ex1_eu_sel.lsu && eu_full.lsu);

  // unit asks to see the same inst again next cycle
  assign issue_stall = ex1.ex1_inst_vld && (mult_issue_stall || cp0_issue_stall);

  assign ex1.ex1_stall = eu_full_hit || issue_stall || int_stall;

  // ------------------------------------------------------------
  // selects
  // ------------------------------------------------------------
  // datapath select ignores commit so operands can move early
  assign dp_sel.alu  = ex1.ex1_eu_sel.alu && !int_stall;
  assign dp_sel.bju  = ex1.ex1_eu_sel.bju && !int_stall && !eu_full.bju;
  assign dp_sel.mult = ex1.ex1_eu_sel.mult && !int_stall && !eu_full.mult;
  assign dp_sel.div  = ex1.ex1_eu_sel.div && !int_stall && !eu_full.div;
  assign dp_sel.lsu  = ex1.ex1_eu_sel.lsu && !int_stall && !eu_full.lsu;
  assign dp_sel.cp0  = ex1.ex1_eu_sel.cp0 && !int_stall;

  // no commit means rtu flushes, so nothing is issued
  assign issue_sel = commit ? dp_sel : '0;

  assign ex1_pipedown_vld = ex1.ex1_inst_vld && !ex1.ex1_stall && commit;

endmodule

//--- source/idu_hpcp_sample.sv
// event bits for the counters, sampled only while counting is enabled
`timescale 1ns/1ns
module idu_hpcp_sample (
  input  logic                ex1_hpcp_clk,
  input  logic                cpurst_b,
  input  logic                cnt_en,
  input  idu_pkg::eu_sel_t    issue_sel,
  input  logic                inst_csr,
  input  logic                inst_sync,
  input  logic                inst_amo,
  input  logic                inst_ecall,
  input  logic                cp0_issue_stall,
  input  logic                dis_stall,
  input  logic                id_inst_vld,
  output idu_pkg::hpcp_type_t hpcp_inst_type,
  output logic                hpcp_backend_stall,
  output logic                hpcp_frontend_stall
);
  import idu_pkg::*;

  hpcp_type_t inst_type;

  // ------------------------------------------------------------
  // classify the issued inst
  // ------------------------------------------------------------
  assign inst_type.int_inst   = issue_sel.alu || issue_sel.mult || issue_sel.div;
  assign inst_type.lsu_inst   = issue_sel.lsu;
  assign inst_type.csr_inst   = issue_sel.cp0 && inst_csr;
  // fence counts once it leaves cp0, amo counts as sync
  assign inst_type.sync_inst  = (issue_sel.cp0 && inst_sync && !cp0_issue_stall)
                                || (issue_sel.lsu && inst_amo);
  assign inst_type.ecall_inst = issue_sel.cp0 && inst_ecall;

  // hold last sample while counting is off
  always_ff @(posedge ex1_hpcp_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      hpcp_inst_type      <= '0;
      hpcp_backend_stall  <= 1'b0;
      hpcp_frontend_stall <= 1'b0;
    end else if (cnt_en) begin
      hpcp_inst_type      <= inst_type;
      hpcp_backend_stall  <= dis_stall;
      // frontend starves when id is idle and not stalled
      hpcp_frontend_stall <= !dis_stall && !id_inst_vld;
    end
  end

endmodule

//--- source/idu_id_top.sv
// issue control top; ports carry exactly three sources and two destinations
`timescale 1ns/1ns
module idu_id_top #(
  parameter int NUM_SRC = idu_pkg::NUM_SRC,
  parameter int NUM_DST = idu_pkg::NUM_DST
) (
  input  logic                ex1_hpcp_clk,
  input  logic                cpurst_b,
  // decoded inst
  input  logic                id_inst_vld,
  input  logic                src0_vld,
  input  logic                src1_vld,
  input  logic                src2_vld,
  input  logic                src0_fwd_vld,
  input  logic                src1_fwd_vld,
  input  logic                src2_fwd_vld,
  input  idu_pkg::wb_info_t   src0_info,
  input  idu_pkg::wb_info_t   src1_info,
  input  idu_pkg::wb_info_t   src2_info,
  input  logic                src_is_bju,
  input  logic                condbr,
  input  logic                store,
  input  logic                dst0_vld,
  input  logic                dst1_vld,
  input  idu_pkg::wb_type_e   dst0_type,
  input  idu_pkg::wb_type_e   dst1_type,
  input  idu_pkg::wb_info_t   dst0_info,
  input  idu_pkg::wb_info_t   dst1_info,
  input  logic                cp0_fence,
  input  logic                expt_vld,
  input  logic                inst_cancel,
  input  idu_pkg::eu_sel_t    dis_eu,
  input  logic                inst_csr,
  input  logic                inst_sync,
  input  logic                inst_amo,
  input  logic                inst_ecall,
  // retire and debug
  input  logic                pipeline_empty,
  input  logic                dbgon,
  input  logic                dis_fence_in_dbg,
  input  logic                flush_stall,
  input  logic                flush_fe,
  input  logic                iu_cancel,
  input  logic                commit,
  // unit status
  input  logic                bju_full,
  input  logic                mult_full,
  input  logic                div_full,
  input  logic                lsu_full,
  input  logic                bju_global_full,
  input  logic                lsu_global_full,
  input  logic                mult_issue_stall,
  input  logic                cp0_issue_stall,
  input  logic                cnt_en,
  // outputs
  output logic                id_stall,
  output logic                ex1_inst_vld,
  output logic                ex1_pipedown_vld,
  output logic                alu_sel,
  output logic                bju_sel,
  output logic                mult_sel,
  output logic                div_sel,
  output logic                lsu_sel,
  output logic                cp0_sel,
  output logic                alu_dp_sel,
  output logic                bju_dp_sel,
  output logic                mult_dp_sel,
  output logic                div_dp_sel,
  output logic                lsu_dp_sel,
  output logic                cp0_dp_sel,
  output idu_pkg::hpcp_type_t hpcp_inst_type,
  output logic                hpcp_backend_stall,
  output logic                hpcp_frontend_stall
);
  import idu_pkg::*;

  wire flush = flush_fe || iu_cancel;

  logic     raw;
  logic     waw;
  logic     dis_stall;
  wb_info_t src_info [NUM_SRC];
  wb_info_t dst_info [NUM_DST];
  wb_type_e dst_type [NUM_DST];
  eu_full_t eu_full;
  eu_sel_t  issue_sel;
  eu_sel_t  dp_sel;

  idu_ex1_if ex1_if ();

  // ------------------------------------------------------------
  // gather per-operand ports into arrays
  // ------------------------------------------------------------
  assign src_info[0] = src0_info;
  assign src_info[1] = src1_info;
  assign src_info[2] = src2_info;
  assign dst_info[0] = dst0_info;
  assign dst_info[1] = dst1_info;
  assign dst_type[0] = dst0_type;
  assign dst_type[1] = dst1_type;
  assign eu_full     = '{bju: bju_full, mult: mult_full, div: div_full, lsu: lsu_full};

  idu_raw_chk #(.NUM_SRC(NUM_SRC)) u_raw_chk (
    .src_vld     ({src2_vld, src1_vld, src0_vld}),
    .src_fwd_vld ({src2_fwd_vld, src1_fwd_vld, src0_fwd_vld}),
    .src_info    (src_info),
    .src_is_bju  (src_is_bju),
    .condbr      (condbr),
    .store       (store),
    .raw         (raw)
  );

  idu_waw_chk #(.NUM_DST(NUM_DST)) u_waw_chk (
    .dst_vld  ({dst1_vld, dst0_vld}),
    .dst_type (dst_type),
    .dst_info (dst_info),
    .waw      (waw)
  );

  idu_dis_ctrl u_dis_ctrl (
    .id_inst_vld      (id_inst_vld),
    .raw              (raw),
    .waw              (waw),
    .cp0_fence        (cp0_fence),
    .pipeline_empty   (pipeline_empty),
    .dbgon            (dbgon),
    .dis_fence_in_dbg (dis_fence_in_dbg),
    .flush_stall      (flush_stall),
    .expt_vld         (expt_vld),
    .inst_cancel      (inst_cancel),
    .dis_eu           (dis_eu),
    .dis_stall        (dis_stall),
    .ex1              (ex1_if.dis)
  );

  idu_ex1_stage u_ex1_stage (
    .ex1_hpcp_clk (ex1_hpcp_clk),
    .cpurst_b     (cpurst_b),
    .flush        (flush),
    .ex1          (ex1_if.stage)
  );

  idu_eu_issue u_eu_issue (
    .commit           (commit),
    .eu_full          (eu_full),
    .bju_global_full  (bju_global_full),
    .lsu_global_full  (lsu_global_full),
    .mult_issue_stall (mult_issue_stall),
    .cp0_issue_stall  (cp0_issue_stall),
    .issue_sel        (issue_sel),
    .dp_sel           (dp_sel),
    .ex1_pipedown_vld (ex1_pipedown_vld),
    .ex1              (ex1_if.issue)
  );

  idu_hpcp_sample u_hpcp_sample (
    .ex1_hpcp_clk        (ex1_hpcp_clk),
    .cpurst_b            (cpurst_b),
    .cnt_en              (cnt_en),
    .issue_sel           (issue_sel),
    .inst_csr            (inst_csr),
    .inst_sync           (inst_sync),
    .inst_amo            (inst_amo),
    .inst_ecall          (inst_ecall),
    .cp0_issue_stall     (cp0_issue_stall),
    .dis_stall           (dis_stall),
    .id_inst_vld         (id_inst_vld),
    .hpcp_inst_type      (hpcp_inst_type),
    .hpcp_backend_stall  (hpcp_backend_stall),
    .hpcp_frontend_stall (hpcp_frontend_stall)
  );

  // ------------------------------------------------------------
  // flatten to per-unit ports
  // ------------------------------------------------------------
  assign id_stall     = dis_stall;
  assign ex1_inst_vld = ex1_if.ex1_inst_vld;
  assign {alu_sel, bju_sel, mult_sel, div_sel, lsu_sel, cp0_sel} = issue_sel;
  assign {alu_dp_sel, bju_dp_sel, mult_dp_sel, div_dp_sel, lsu_dp_sel, cp0_dp_sel} = dp_sel;

endmodule

//--- tests/tb_idu_id.sv
// directed checks of the issue control; inputs change 1 ns after the rising clock edge
`timescale 1ns/1ns
module tb_idu_id;
  import idu_pkg::*;

  localparam int         RST_CYCLES = 16;
  localparam int         WAIT_MAX   = 50;
  // select order is alu, bju, mult, div, lsu, cp0 from the top bit down
  localparam eu_sel_t    SEL_NONE   = 6'b000000;
  localparam eu_sel_t    SEL_ALU    = 6'b100000;
  localparam eu_sel_t    SEL_LSU    = 6'b000010;
  localparam eu_sel_t    SEL_CP0    = 6'b000001;
  // event order is int, lsu, csr, sync, ecall from the top bit down
  localparam hpcp_type_t HP_NONE    = 5'b00000;
  localparam hpcp_type_t HP_INT     = 5'b10000;
  localparam hpcp_type_t HP_LSU     = 5'b01000;
  localparam hpcp_type_t HP_CSR     = 5'b00100;

  logic       ex1_hpcp_clk;
  logic       cpurst_b;
  logic       id_inst_vld;
  logic       src0_vld, src1_vld, src2_vld;
  logic       src0_fwd_vld, src1_fwd_vld, src2_fwd_vld;
  wb_info_t   src0_info, src1_info, src2_info;
  logic       src_is_bju, condbr, store;
  logic       dst0_vld, dst1_vld;
  wb_type_e   dst0_type, dst1_type;
  wb_info_t   dst0_info, dst1_info;
  logic       cp0_fence, expt_vld, inst_cancel;
  eu_sel_t    dis_eu;
  logic       inst_csr, inst_sync, inst_amo, inst_ecall;
  logic       pipeline_empty, dbgon, dis_fence_in_dbg, flush_stall;
  logic       flush_fe, iu_cancel, commit;
  logic       bju_full, mult_full, div_full, lsu_full;
  logic       bju_global_full, lsu_global_full, mult_issue_stall, cp0_issue_stall;
  logic       cnt_en;
  logic       id_stall, ex1_inst_vld, ex1_pipedown_vld;
  logic       alu_sel, bju_sel, mult_sel, div_sel, lsu_sel, cp0_sel;
  logic       alu_dp_sel, bju_dp_sel, mult_dp_sel, div_dp_sel, lsu_dp_sel, cp0_dp_sel;
  hpcp_type_t hpcp_inst_type;
  logic       hpcp_backend_stall, hpcp_frontend_stall;

  // per-unit outputs packed back for whole-vector compares
  eu_sel_t    issue_vec;
  eu_sel_t    dp_vec;
  string      test_name;

  assign issue_vec = {alu_sel, bju_sel, mult_sel, div_sel, lsu_sel, cp0_sel};
  assign dp_vec    = {alu_dp_sel, bju_dp_sel, mult_dp_sel, div_dp_sel, lsu_dp_sel, cp0_dp_sel};

  idu_id_top u_dut (.*);

  initial ex1_hpcp_clk = 1'b0;
  always #2 ex1_hpcp_clk = ~ex1_hpcp_clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("Fail %s %s: expected %b actual %b", test_name, what, exp, act));
  endtask

  task automatic check_eu_sel(input string what, input eu_sel_t exp, input eu_sel_t act);
    if (act !== exp)
      stop_run($sformatf("Fail %s %s: expected %b actual %b", test_name, what, exp, act));
  endtask

  task automatic check_hpcp(input string what, input hpcp_type_t exp, input hpcp_type_t act);
    if (act !== exp)
      stop_run($sformatf("Fail %s %s: expected %b actual %b", test_name, what, exp, act));
  endtask

  // register with a pending producer
  function automatic wb_info_t pending_info(input wb_type_e prod, input logic [1:0] cnt,
                                            input logic cnt2);
    wb_info_t info;
    info.vld     = 1'b0;
    info.wb_type = prod;
    info.cnt     = cnt;
    info.wb_cnt2 = cnt2;
    return info;
  endfunction

  function automatic wb_info_t free_info();
    wb_info_t info;
    info         = '0;
    info.vld     = 1'b1;
    return info;
  endfunction

  task automatic next_cycle();
    @(posedge ex1_hpcp_clk);
    #1;
  endtask

  // quiet pipe with no inst and nothing pending, commit on and units free
  task automatic idle_inputs();
    id_inst_vld      = 1'b0;
    {src0_vld, src1_vld, src2_vld}             = '0;
    {src0_fwd_vld, src1_fwd_vld, src2_fwd_vld} = '0;
    src0_info        = free_info();
    src1_info        = free_info();
    src2_info        = free_info();
    {src_is_bju, condbr, store} = '0;
    {dst0_vld, dst1_vld}        = '0;
    dst0_type        = WB_ALU;
    dst1_type        = WB_ALU;
    dst0_info        = free_info();
    dst1_info        = free_info();
    {cp0_fence, expt_vld, inst_cancel}          = '0;
    dis_eu           = SEL_NONE;
    {inst_csr, inst_sync, inst_amo, inst_ecall} = '0;
    pipeline_empty   = 1'b1;
    {dbgon, dis_fence_in_dbg, flush_stall}      = '0;
    {flush_fe, iu_cancel}                       = '0;
    commit           = 1'b1;
    {bju_full, mult_full, div_full, lsu_full}   = '0;
    {bju_global_full, lsu_global_full}          = '0;
    {mult_issue_stall, cp0_issue_stall}         = '0;
    cnt_en           = 1'b0;
  endtask

  // fresh inst on its own cycle with everything else idle
  task automatic offer_inst(input eu_sel_t eu);
    next_cycle();
    idle_inputs();
    id_inst_vld = 1'b1;
    dis_eu      = eu;
  endtask

  task automatic wait_stall_clear();
    int n;
    n = 0;
    while (id_stall && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (id_stall) stop_run("id_stall stayed high with the pipe idle");
  endtask

  task automatic wait_lsu_issue();
    int n;
    n = 0;
    while (!lsu_sel && n < WAIT_MAX) begin
      next_cycle();
      #1;
      n++;
    end
    if (!lsu_sel) stop_run("lsu issue select never rose after lsu_full cleared");
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic reset_test();
    test_name = "reset";
    check_bit("id_stall", 1'b0, id_stall);
    check_bit("ex1_inst_vld", 1'b0, ex1_inst_vld);
    check_bit("ex1_pipedown_vld", 1'b0, ex1_pipedown_vld);
    check_eu_sel("issue_sel", SEL_NONE, issue_vec);
    check_eu_sel("dp_sel", SEL_NONE, dp_vec);
    check_hpcp("hpcp_inst_type", HP_NONE, hpcp_inst_type);
    check_bit("backend_stall", 1'b0, hpcp_backend_stall);
    check_bit("frontend_stall", 1'b0, hpcp_frontend_stall);
  endtask

  task automatic raw_test();
    test_name = "raw";
    // deep lsu queue beats forwarding
    offer_inst(SEL_ALU);
    src0_vld     = 1'b1;
    src0_fwd_vld = 1'b1;
    src0_info    = pending_info(WB_LSU, 2'd2, 1'b0);
    #1 check_bit("lsu cnt2 stall", 1'b1, id_stall);
    offer_inst(SEL_ALU);
    src0_vld  = 1'b1;
    src0_info = pending_info(WB_ALU, 2'd2, 1'b0);
    #1 check_bit("alu producer", 1'b0, id_stall);
    // load into conditional branch
    offer_inst(SEL_ALU);
    {src_is_bju, condbr, src0_vld} = 3'b111;
    src0_info = pending_info(WB_LSU, 2'd0, 1'b0);
    #1 check_bit("load to condbr cnt0", 1'b0, id_stall);
    offer_inst(SEL_ALU);
    {src_is_bju, condbr, src0_vld} = 3'b111;
    src0_info = pending_info(WB_LSU, 2'd2, 1'b0);
    #1 check_bit("load to condbr cnt2", 1'b1, id_stall);
    // store data is only the last source
    offer_inst(SEL_ALU);
    {store, src2_vld} = 2'b11;
    src2_info = pending_info(WB_LSU, 2'd2, 1'b1);
    #1 check_bit("load to store data", 1'b0, id_stall);
    offer_inst(SEL_ALU);
    {store, src0_vld} = 2'b11;
    src0_info = pending_info(WB_LSU, 2'd2, 1'b1);
    #1 check_bit("load to store addr", 1'b1, id_stall);
  endtask

  task automatic waw_test();
    test_name = "waw";
    offer_inst(SEL_LSU);
    dst0_vld  = 1'b1;
    dst0_type = WB_LSU;
    dst0_info = pending_info(WB_LSU, 2'd1, 1'b0);
    #1 check_bit("lsu after lsu", 1'b0, id_stall);
    offer_inst(SEL_LSU);
    dst0_vld  = 1'b1;
    dst0_type = WB_LSU;
    dst0_info = pending_info(WB_MULT, 2'd0, 1'b0);
    #1 check_bit("lsu after mult", 1'b1, id_stall);
    offer_inst(SEL_ALU);
    dst1_vld  = 1'b1;
    dst1_type = WB_DIV;
    dst1_info = pending_info(WB_ALU, 2'd2, 1'b0);
    #1 check_bit("alu old producer", 1'b0, id_stall);
  endtask

  task automatic fence_flush_test();
    test_name = "fence";
    offer_inst(SEL_CP0);
    cp0_fence      = 1'b1;
    pipeline_empty = 1'b0;
    #1 check_bit("fence busy pipe", 1'b1, id_stall);
    next_cycle();
    dbgon = 1'b1;
    #1 check_bit("fence dbg only", 1'b1, id_stall);
    next_cycle();
    dis_fence_in_dbg = 1'b1;
    #1 check_bit("fence in dbg", 1'b0, id_stall);
    offer_inst(SEL_CP0);
    cp0_fence = 1'b1;
    #1 check_bit("fence empty pipe", 1'b0, id_stall);
    test_name = "flush";
    offer_inst(SEL_LSU);
    flush_fe = 1'b1;
    next_cycle();
    idle_inputs();
    #1 check_bit("ex1_inst_vld", 1'b0, ex1_inst_vld);
    check_eu_sel("issue_sel", SEL_NONE, issue_vec);
  endtask

  task automatic issue_test();
    test_name = "issue";
    wait_stall_clear();
    offer_inst(SEL_LSU);
    #1 check_bit("accept", 1'b0, id_stall);
    next_cycle();
    id_inst_vld = 1'b0;
    #1 check_bit("ex1_inst_vld", 1'b1, ex1_inst_vld);
    check_eu_sel("issue_sel", SEL_LSU, issue_vec);
    check_eu_sel("dp_sel", SEL_LSU, dp_vec);
    check_bit("ex1_pipedown_vld", 1'b1, ex1_pipedown_vld);
    // lsu full holds the next lsu inst in ex1
    test_name = "lsu_full";
    next_cycle();
    id_inst_vld = 1'b1;
    lsu_full    = 1'b1;
    #1 check_bit("accept", 1'b0, id_stall);
    repeat (3) begin
      next_cycle();
      id_inst_vld = 1'b0;
      #1 check_bit("ex1 held", 1'b1, ex1_inst_vld);
      check_bit("lsu_sel", 1'b0, lsu_sel);
      check_bit("lsu_dp_sel", 1'b0, lsu_dp_sel);
      check_bit("id_stall", 1'b1, id_stall);
    end
    next_cycle();
    lsu_full = 1'b0;
    #1 wait_lsu_issue();
    check_bit("ex1 after full", 1'b1, ex1_inst_vld);
    check_bit("id_stall cleared", 1'b0, id_stall);
    // faulting inst remapped to cp0
    test_name = "expt";
    next_cycle();
    id_inst_vld = 1'b1;
    dis_eu      = SEL_ALU | SEL_LSU;
    expt_vld    = 1'b1;
    #1 check_bit("accept", 1'b0, id_stall);
    next_cycle();
    id_inst_vld = 1'b0;
    expt_vld    = 1'b0;
    #1 check_eu_sel("issue_sel", SEL_CP0, issue_vec);
    check_eu_sel("dp_sel", SEL_CP0, dp_vec);
  endtask

  task automatic hpcp_test();
    test_name = "hpcp";
    wait_stall_clear();
    offer_inst(SEL_ALU);
    cnt_en = 1'b1;
    #1 check_bit("accept", 1'b0, id_stall);
    next_cycle();
    dis_eu = SEL_LSU;
    #1 check_eu_sel("alu issue", SEL_ALU, issue_vec);
    next_cycle();
    dis_eu   = SEL_CP0;
    inst_csr = 1'b1;
    #1 check_hpcp("int event", HP_INT, hpcp_inst_type);
    check_eu_sel("lsu issue", SEL_LSU, issue_vec);
    next_cycle();
    id_inst_vld = 1'b0;
    #1 check_hpcp("lsu event", HP_LSU, hpcp_inst_type);
    check_eu_sel("cp0 issue", SEL_CP0, issue_vec);
    next_cycle();
    cnt_en   = 1'b0;
    inst_csr = 1'b0;
    #1 check_hpcp("csr event", HP_CSR, hpcp_inst_type);
    check_bit("frontend idle", 1'b1, hpcp_frontend_stall);
    check_bit("backend idle", 1'b0, hpcp_backend_stall);
    // new issue and a dispatch stall must not reach the outputs while counting is off
    next_cycle();
    id_inst_vld = 1'b1;
    dis_eu      = SEL_ALU;
    next_cycle();
    id_inst_vld = 1'b0;
    flush_stall = 1'b1;
    #1 check_eu_sel("alu issue off", SEL_ALU, issue_vec);
    check_bit("stall while off", 1'b1, id_stall);
    next_cycle();
    flush_stall = 1'b0;
    #1 check_hpcp("held event", HP_CSR, hpcp_inst_type);
    check_bit("held frontend", 1'b1, hpcp_frontend_stall);
    check_bit("held backend", 1'b0, hpcp_backend_stall);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    idle_inputs();
    cpurst_b  = 1'b0;
    test_name = "init";
    repeat (RST_CYCLES) @(posedge ex1_hpcp_clk);
    #1;
    cpurst_b = 1'b1;
    #1;
    reset_test();
    raw_test();
    waw_test();
    fence_flush_test();
    issue_test();
    hpcp_test();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sources.f
source/idu_pkg.sv
source/idu_ex1_if.sv
source/idu_raw_chk.sv
source/idu_waw_chk.sv
source/idu_dis_ctrl.sv
source/idu_ex1_stage.sv
source/idu_eu_issue.sv
source/idu_hpcp_sample.sv
source/idu_id_top.sv
tests/tb_idu_id.sv
